//--- source/mem_wb_params.svh
`ifndef MEM_WB_PARAMS_SVH
`define MEM_WB_PARAMS_SVH

`define MW_XLEN 32
`define MW_REG_COUNT 32
`define MW_REG_ADDR_W $clog2(`MW_REG_COUNT)

// ADDI x0, x0, 0
`define MW_NOP_INSTR 32'h0000_0013

`endif

//--- source/mem_wb_pkg.sv
`include "mem_wb_params.svh"

package mem_wb_pkg;

    // I-type layout, used by loads and for the rd field
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // U-type layout, carries the upper immediate of LUI
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef union packed {
        instr_i_t i;
        instr_u_t u;
    } instr_word_t;

    typedef enum logic [2:0] {
        WB_SRC_ALU  = 3'd0,
        WB_SRC_LOAD = 3'd1,
        WB_SRC_PC4  = 3'd2,
        WB_SRC_LUI  = 3'd3,
        WB_SRC_CSR  = 3'd4
    } wb_src_e;

    typedef struct packed {
        logic [`MW_XLEN-1:0] pc;
        instr_word_t         instruction;
        logic [`MW_XLEN-1:0] alu_result;
        logic [`MW_XLEN-1:0] csr_read_data;
        wb_src_e             wb_src;
        logic                register_write_enable;
    } ex_mem_t;

    typedef struct packed {
        logic [`MW_XLEN-1:0] pc;
        instr_word_t         instruction;
        logic [`MW_XLEN-1:0] alu_result;
        logic [`MW_XLEN-1:0] csr_read_data;
        logic [`MW_XLEN-1:0] load_data;
        wb_src_e             wb_src;
        logic                register_write_enable;
    } mem_wb_t;

    typedef struct packed {
        logic                      write_enable;
        logic [`MW_REG_ADDR_W-1:0] rd;
        logic [`MW_XLEN-1:0]       data;
    } reg_write_t;

endpackage

//--- source/load_align.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module load_align (
    input  mem_wb_pkg::ex_mem_t  ex_mem,
    input  logic [`MW_XLEN-1:0]  dmem_rdata,
    output mem_wb_pkg::mem_wb_t  mem_out
);
    import mem_wb_pkg::*;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    logic [1:0]          offset;
    logic [2:0]          funct3;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;
    logic [`MW_XLEN-1:0] load_value;

    // The load address is the ALU result
    assign offset = ex_mem.alu_result[1:0];
    assign funct3 = ex_mem.instruction.i.funct3;

    always_comb begin
        case (offset)
            2'd0:    byte_sel = dmem_rdata[7:0];
            2'd1:    byte_sel = dmem_rdata[15:8];
            2'd2:    byte_sel = dmem_rdata[23:16];
            default: byte_sel = dmem_rdata[31:24];
        endcase
        half_sel = offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

        case (funct3)
            F3_LB:   load_value = {{(`MW_XLEN-8){byte_sel[7]}}, byte_sel};
            F3_LH:   load_value = {{(`MW_XLEN-16){half_sel[15]}}, half_sel};
            F3_LBU:  load_value = {{(`MW_XLEN-8){1'b0}}, byte_sel};
            F3_LHU:  load_value = {{(`MW_XLEN-16){1'b0}}, half_sel};
            F3_LW:   load_value = dmem_rdata;
            default: load_value = dmem_rdata;
        endcase
    end

    always_comb begin
        mem_out.pc                    = ex_mem.pc;
        mem_out.instruction           = ex_mem.instruction;
        mem_out.alu_result            = ex_mem.alu_result;
        mem_out.csr_read_data         = ex_mem.csr_read_data;
        mem_out.load_data             = load_value;
        mem_out.wb_src                = ex_mem.wb_src;
        mem_out.register_write_enable = ex_mem.register_write_enable;
    end

    // Misaligned loads are trapped earlier in the pipe and must not arrive here
    always_comb begin
        if (ex_mem.register_write_enable && ex_mem.wb_src == WB_SRC_LOAD) begin
            assert ((funct3[1:0] != 2'b01 || offset[0] == 1'b0) &&
                    (funct3[1:0] != 2'b10 || offset == 2'b00))
                else $error("misaligned load, funct3 %0d offset %0d", funct3, offset);
        end
    end

endmodule

//--- source/mem_wb_register.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module mem_wb_register (
    input  logic                clk,
    input  logic                reset,
    input  mem_wb_pkg::mem_wb_t mem_in,
    output mem_wb_pkg::mem_wb_t wb_out
);

    // No stall and no flush, so the record moves on every edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_out <= '0;
            // Bubble carries a NOP so the instruction field decodes cleanly
            wb_out.instruction <= `MW_NOP_INSTR;
        end else begin
            wb_out <= mem_in;
        end
    end

    assert property (@(posedge clk) reset |-> !wb_out.register_write_enable)
        else $error("write enable seen in writeback during reset");

endmodule

//--- source/writeback_select.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module writeback_select (
    input  mem_wb_pkg::mem_wb_t    wb_in,
    output mem_wb_pkg::reg_write_t reg_write
);
    import mem_wb_pkg::*;

    logic [`MW_REG_ADDR_W-1:0] rd;
    logic [`MW_XLEN-1:0]       pc_plus_4;
    logic [`MW_XLEN-1:0]       lui_value;
    logic [`MW_XLEN-1:0]       result;

    // rd sits at the same bits in both views
    assign rd        = wb_in.instruction.i.rd;
    assign pc_plus_4 = wb_in.pc + `MW_XLEN'(4);
    assign lui_value = {wb_in.instruction.u.imm20, 12'b0};

    always_comb begin
        case (wb_in.wb_src)
            WB_SRC_ALU:  result = wb_in.alu_result;
            WB_SRC_LOAD: result = wb_in.load_data;
            WB_SRC_PC4:  result = pc_plus_4;
            WB_SRC_LUI:  result = lui_value;
            WB_SRC_CSR:  result = wb_in.csr_read_data;
            default:     result = '0;
        endcase
    end

    // x0 is dropped here, the register file never sees a write to it
    always_comb begin
        reg_write.write_enable = wb_in.register_write_enable && (rd != '0);
        reg_write.rd           = rd;
        reg_write.data         = result;
    end

    always_comb begin
        if (reg_write.write_enable) begin
            assert (wb_in.wb_src inside {WB_SRC_ALU, WB_SRC_LOAD, WB_SRC_PC4,
                                         WB_SRC_LUI, WB_SRC_CSR})
                else $error("illegal writeback source %0d", wb_in.wb_src);
        end
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  mem_wb_pkg::reg_write_t       reg_write,
    input  logic [`MW_REG_ADDR_W-1:0]    rs1_addr,
    input  logic [`MW_REG_ADDR_W-1:0]    rs2_addr,
    output logic [`MW_XLEN-1:0]          rs1_data,
    output logic [`MW_XLEN-1:0]          rs2_data
);

    // Entry 0 is not stored at all
    logic [`MW_XLEN-1:0] regs [1:`MW_REG_COUNT-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `MW_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.write_enable) begin
            regs[reg_write.rd] <= reg_write.data;
        end
    end

    // A write in flight is forwarded so decode sees it in the same cycle
    function automatic logic [`MW_XLEN-1:0] read_port(
        input logic [`MW_REG_ADDR_W-1:0] addr
    );
        logic [`MW_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (reg_write.write_enable && reg_write.rd == addr) begin
            value = reg_write.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
    end

    always_comb begin
        rs2_data = read_port(rs2_addr);
    end

    assert property (@(posedge clk) disable iff (reset)
                     reg_write.write_enable |-> reg_write.rd != '0)
        else $error("register write aimed at x0");

endmodule

//--- source/mem_wb_top.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module mem_wb_top (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_wb_pkg::ex_mem_t       ex_mem,
    input  logic [`MW_XLEN-1:0]       dmem_rdata,
    input  logic [`MW_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`MW_REG_ADDR_W-1:0] rs2_addr,
    output logic [`MW_XLEN-1:0]       rs1_data,
    output logic [`MW_XLEN-1:0]       rs2_data,
    output mem_wb_pkg::reg_write_t    reg_write
);
    import mem_wb_pkg::*;

    mem_wb_t mem_record;
    mem_wb_t wb_record;

    load_align i_load_align (
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .mem_out    (mem_record)
    );

    mem_wb_register i_mem_wb_register (
        .clk    (clk),
        .reset  (reset),
        .mem_in (mem_record),
        .wb_out (wb_record)
    );

    writeback_select i_writeback_select (
        .wb_in     (wb_record),
        .reg_write (reg_write)
    );

    register_file i_register_file (
        .clk       (clk),
        .reset     (reset),
        .reg_write (reg_write),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

endmodule

//--- sim/tb_mem_wb.sv
`timescale 1ns/100ps
`include "mem_wb_params.svh"

module tb_mem_wb;
    import mem_wb_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int CASE_WORDS   = 7;
    localparam int MAX_CASES    = 64;
    localparam int TEST_COUNT   = 5;
    localparam int ADDR_W       = `MW_REG_ADDR_W;
    localparam int HALF_REGS    = `MW_REG_COUNT / 2;

    logic                clk;
    logic                reset;
    ex_mem_t             ex_mem;
    logic [`MW_XLEN-1:0] dmem_rdata;
    logic [ADDR_W-1:0]   rs1_addr;
    logic [ADDR_W-1:0]   rs2_addr;
    logic [`MW_XLEN-1:0] rs1_data;
    logic [`MW_XLEN-1:0] rs2_data;
    reg_write_t          reg_write;

    logic [31:0]         case_mem [0:CASE_WORDS*MAX_CASES-1];
    logic [`MW_XLEN-1:0] model [0:`MW_REG_COUNT-1];
    int                  num_cases;
    bit                  cases_loaded = 1'b0;
    int                  check_count;
    int                  error_count;
    int                  test_errors [1:TEST_COUNT];
    logic [31:0]         lfsr_state;

    mem_wb_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .reg_write  (reg_write)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_reg_addr(output logic [ADDR_W-1:0] addr);
        addr = '0;
        for (int b = 0; b < ADDR_W; b++) begin
            addr = {addr[ADDR_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int case_group(input int idx);
        return int'(case_mem[idx * CASE_WORDS + 5][15:12]);
    endfunction

    function automatic string test_title(input int test_id);
        case (test_id)
            1:       return "reset state";
            2:       return "load alignment";
            3:       return "source selection";
            4:       return "x0 and bubbles";
            default: return "back-to-back state and bypass";
        endcase
    endfunction

    task automatic check_value(input int test_id, input string name,
                               input logic [31:0] actual, input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors[test_id]++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input int test_id);
        if (test_errors[test_id] == 0) begin
            $display("test %0d %s: ok", test_id, test_title(test_id));
        end else begin
            $display("test %0d %s: %0d errors", test_id, test_title(test_id),
                     test_errors[test_id]);
        end
    endtask

    task automatic load_cases();
        for (int i = 0; i < CASE_WORDS * MAX_CASES; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("sim/mem_wb_cases.txt", case_mem);
        // Every real case carries a nonzero test number in its ctrl word
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases * CASE_WORDS + 5] != 32'd0) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            error_count++;
            $display("no cases could be read from sim/mem_wb_cases.txt");
        end
        cases_loaded = 1'b1;
    endtask

    // Registers 0 to 15 on rs1 and 16 to 31 on rs2, one pair per cycle
    task automatic check_reset_state();
        // The bubble from reset is still in writeback until the next rising edge
        check_value(1, "reg_write.write_enable", 32'(reg_write.write_enable), 32'd0);
        for (int i = 0; i < HALF_REGS; i++) begin
            rs1_addr = ADDR_W'(i);
            rs2_addr = ADDR_W'(i + HALF_REGS);
            @(negedge clk);
            check_value(1, "reg_write.write_enable", 32'(reg_write.write_enable), 32'd0);
            check_value(1, "rs1_data", rs1_data, 32'd0);
            check_value(1, "rs2_data", rs2_data, 32'd0);
        end
        report_test(1);
    endtask

    task automatic apply_case(input int idx);
        logic [31:0] ctrl;
        ctrl = case_mem[idx * CASE_WORDS + 5];
        ex_mem.pc                    = case_mem[idx * CASE_WORDS];
        ex_mem.instruction           = case_mem[idx * CASE_WORDS + 1];
        ex_mem.alu_result            = case_mem[idx * CASE_WORDS + 2];
        ex_mem.csr_read_data         = case_mem[idx * CASE_WORDS + 3];
        ex_mem.wb_src                = wb_src_e'(ctrl[10:8]);
        ex_mem.register_write_enable = ctrl[4];
        dmem_rdata                   = case_mem[idx * CASE_WORDS + 4];
        // rs1 follows this record so its read lands on the bypass next cycle
        rs1_addr = case_mem[idx * CASE_WORDS + 1][11:7];
        random_reg_addr(rs2_addr);
    endtask

    task automatic check_case(input int idx);
        logic [31:0]       ctrl;
        logic [31:0]       expected_data;
        logic [ADDR_W-1:0] rd;
        int                test_id;
        ctrl          = case_mem[idx * CASE_WORDS + 5];
        expected_data = case_mem[idx * CASE_WORDS + 6];
        rd            = case_mem[idx * CASE_WORDS + 1][11:7];
        test_id       = case_group(idx);
        check_value(test_id, "reg_write.write_enable", 32'(reg_write.write_enable),
                    32'(ctrl[0]));
        if (ctrl[0]) begin
            check_value(test_id, "reg_write.rd", 32'(reg_write.rd), 32'(rd));
            check_value(test_id, "reg_write.data", reg_write.data, expected_data);
            model[rd] = expected_data;
        end
        // Both ports already show the state after this write
        check_value(5, "rs1_data", rs1_data, model[rs1_addr]);
        check_value(5, "rs2_data", rs2_data, model[rs2_addr]);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        ex_mem     = '0;
        // A live write to x1 waits at the inputs while reset holds the pipeline
        ex_mem.instruction           = 32'h0010_0093;
        ex_mem.alu_result            = 32'd1;
        ex_mem.register_write_enable = 1'b1;
        dmem_rdata = '0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        lfsr_state = 32'd88549;
        check_count = 0;
        error_count = 0;
        for (int t = 1; t <= TEST_COUNT; t++) begin
            test_errors[t] = 0;
        end
        for (int r = 0; r < `MW_REG_COUNT; r++) begin
            model[r] = '0;
        end
        load_cases();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        ex_mem = '0;
        check_reset_state();

        for (int k = 0; k <= num_cases; k++) begin
            if (k > 0) begin
                @(negedge clk);
                check_case(k - 1);
                if (k == num_cases || case_group(k) != case_group(k - 1)) begin
                    report_test(case_group(k - 1));
                end
            end
            if (k < num_cases) begin
                apply_case(k);
            end
        end
        report_test(5);

        $display("%0d tests, %0d checks, %0d errors", TEST_COUNT, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Run length is the case count plus reset and drain margin
    initial begin
        wait (cases_loaded);
        #((num_cases + 20) * CLK_PERIOD);
        $display("timeout after %0d cycles, the test sequence did not finish", num_cases + 20);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+source
source/mem_wb_pkg.sv
source/load_align.sv
source/mem_wb_register.sv
source/writeback_select.sv
source/register_file.sv
source/mem_wb_top.sv
sim/tb_mem_wb.sv

//--- Makefile
# Verilator simulation of the MEM/WB back end
# Override any variable on the command line, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/mem_wb_cases.txt
// pc instruction alu_result csr_read_data dmem_rdata ctrl expected_data
// ctrl nibbles [15:12] test number, [10:8] wb_src, [4] register_write_enable, [0] expected write_enable
// expected_data is only compared when the expected write_enable is set
00000100 00010283 00001000 5A5A5A5A 8F7EA5C3 00002111 FFFFFFC3
00000104 00010303 00001001 5A5A5A5A 8F7EA5C3 00002111 FFFFFFA5
00000108 00010383 00001002 5A5A5A5A 8F7EA5C3 00002111 0000007E
0000010C 00010403 00001003 5A5A5A5A 8F7EA5C3 00002111 FFFFFF8F
00000110 00014483 00001000 5A5A5A5A 8F7EA5C3 00002111 000000C3
00000114 00014503 00001001 5A5A5A5A 8F7EA5C3 00002111 000000A5
00000118 00014583 00001002 5A5A5A5A 8F7EA5C3 00002111 0000007E
0000011C 00014603 00001003 5A5A5A5A 8F7EA5C3 00002111 0000008F
00000120 00011683 00001000 5A5A5A5A 8F7EA5C3 00002111 FFFFA5C3
00000124 00011703 00001002 5A5A5A5A 8F7EA5C3 00002111 FFFF8F7E
00000128 00015783 00001000 5A5A5A5A 8F7EA5C3 00002111 0000A5C3
0000012C 00015803 00001002 5A5A5A5A 8F7EA5C3 00002111 00008F7E
00000130 00012883 00001000 5A5A5A5A 8F7EA5C3 00002111 8F7EA5C3
00000134 00011903 00002002 5A5A5A5A 12345678 00002111 00001234
00000138 00010983 00002000 5A5A5A5A 12345678 00002111 00000078
0000013C 00208A33 13579BDF 5A5A5A5A 00000000 00003011 13579BDF
00000140 FFF00A93 FFFFFFFF 5A5A5A5A 00000000 00003011 FFFFFFFF
00000144 05500293 00000055 5A5A5A5A 00000000 00003011 00000055
00000200 008000EF 00000208 5A5A5A5A 00000000 00003211 00000204
FFFFFFFC 00008B67 00000000 5A5A5A5A 00000000 00003211 00000000
00000148 ABCDEBB7 00000000 5A5A5A5A 00000000 00003311 ABCDE000
0000014C 00001C37 00000000 5A5A5A5A 00000000 00003311 00001000
00000150 B0002CF3 00000000 00C0FFEE 00000000 00003411 00C0FFEE
00000154 30001D73 00000000 80000088 00000000 00003411 80000088
00000158 00500013 00000005 5A5A5A5A 00000000 00004010 00000000
0000015C 00012003 00001000 5A5A5A5A 8F7EA5C3 00004110 00000000
00000160 12345037 00000000 5A5A5A5A 00000000 00004310 00000000
00000164 002082B3 FFFFFFFF 5A5A5A5A 00000000 00004000 00000000
00000168 00000013 00000000 00000000 00000000 00004000 00000000
